/* Bender.yml */
package:
  name: led_matrix

sources:
  - hw/led_matrix_pkg.sv
  - hw/fb_read_if.sv
  - hw/uart_rx.sv
  - hw/control_module.sv
  - hw/framebuffer.sv
  - hw/matrix_scan.sv
  - hw/framebuffer_fetch.sv
  - hw/led_matrix_top.sv
  - target: test
    files:
      - tests/led_matrix_assertions.sv
      - tests/led_matrix_tb.sv

/* hw/control_module.sv */
`timescale 1ns/100ps

module control_module (
    input  logic                                   clk_in,
    input  logic                                   rst_n,
    input  logic [7:0]                             rx_data,
    input  logic                                   rx_valid,
    output logic                                   wr_en,
    output logic [led_matrix_pkg::BYTE_ADDR_W-1:0] wr_addr,
    output logic [7:0]                             wr_data,
    output logic [led_matrix_pkg::NUM_PLANES-1:0]  plane_enable
);

    typedef enum logic [1:0] {
        CTRL_CMD,
        CTRL_FRAME,
        CTRL_BRIGHT
    } ctrl_state_t;

    ctrl_state_t                            state;
    logic [led_matrix_pkg::BYTE_ADDR_W-1:0] next_addr;

    always_ff @(posedge clk_in or negedge rst_n) begin
        if (!rst_n) begin
            state        <= CTRL_CMD;
            next_addr    <= '0;
            wr_en        <= 1'b0;
            plane_enable <= '1; // All planes lit
        end else begin
            wr_en <= 1'b0;
            if (rx_valid) begin
                case (state)
                    CTRL_CMD: begin
                        next_addr <= '0;
                        if (rx_data == led_matrix_pkg::CMD_FRAME) state <= CTRL_FRAME;
                        else if (rx_data == led_matrix_pkg::CMD_BRIGHT) state <= CTRL_BRIGHT;
                    end
                    CTRL_FRAME: begin
                        wr_en     <= 1'b1;
                        next_addr <= next_addr + 1'b1;
                        if (next_addr == '1) state <= CTRL_CMD; // Last image byte
                    end
                    CTRL_BRIGHT: begin
                        plane_enable <= rx_data[led_matrix_pkg::NUM_PLANES-1:0];
                        state        <= CTRL_CMD;
                    end
                    default: state <= CTRL_CMD;
                endcase
            end
        end
    end

    // Write payload, qualified by wr_en
    always_ff @(posedge clk_in) begin
        if (rx_valid) begin
            wr_addr <= next_addr;
            wr_data <= rx_data;
        end
    end

endmodule

/* hw/fb_read_if.sv */
`timescale 1ns/100ps

// Framebuffer read port, data returns one cycle after rd_en
interface fb_read_if;

    logic                                  rd_en;
    logic [led_matrix_pkg::PIX_ADDR_W-1:0] rd_addr;
    logic [15:0]                           rd_data; // rgb565 pixel

    modport fetch (
        output rd_en,
        output rd_addr,
        input  rd_data
    );

    modport mem (
        input  rd_en,
        input  rd_addr,
        output rd_data
    );

endinterface

/* hw/framebuffer.sv */
`timescale 1ns/100ps

module framebuffer (
    input  logic                                   clk_in,
    input  logic                                   wr_en,
    input  logic [led_matrix_pkg::BYTE_ADDR_W-1:0] wr_addr,
    input  logic [7:0]                             wr_data,
    fb_read_if.mem                                 rd
);

    logic [15:0] mem [0:led_matrix_pkg::FB_WORDS-1];

    // Even byte address is the low byte of the pixel
    always_ff @(posedge clk_in) begin
        if (wr_en) begin
            if (wr_addr[0]) begin
                mem[wr_addr[led_matrix_pkg::BYTE_ADDR_W-1:1]][15:8] <= wr_data;
            end else begin
                mem[wr_addr[led_matrix_pkg::BYTE_ADDR_W-1:1]][7:0] <= wr_data;
            end
        end
    end

    always_ff @(posedge clk_in) begin
        if (rd.rd_en) rd.rd_data <= mem[rd.rd_addr];
    end

endmodule

/* hw/framebuffer_fetch.sv */
`timescale 1ns/100ps

module framebuffer_fetch (
    input  logic                                  clk_in,
    input  logic                                  rst_n,
    input  logic [led_matrix_pkg::COL_W-1:0]      col_addr,
    input  logic [led_matrix_pkg::ROW_W-1:0]      row_addr,
    input  logic [led_matrix_pkg::PLANE_W-1:0]    plane,
    input  logic                                  load,
    input  logic [led_matrix_pkg::NUM_PLANES-1:0] plane_enable,
    fb_read_if.fetch                              rd,
    output logic [2:0]                            rgb_top,
    output logic [2:0]                            rgb_bot
);

    logic [led_matrix_pkg::ROW_W-1:0]      fetch_row;
    logic [led_matrix_pkg::PIX_ADDR_W-1:0] top_addr;
    logic [led_matrix_pkg::PIX_ADDR_W-1:0] top_addr_q;
    logic [led_matrix_pkg::PLANE_W-1:0]    plane_q;
    logic                                  top_ready; // Top word on rd_data
    logic                                  bot_ready; // Bottom word on rd_data
    logic [2:0]                            top_bits;
    logic                                  plane_on;

    // Bit order is {blue, green, red}
    function automatic logic [2:0] plane_bits(input logic [15:0] pixel,
                                              input logic [led_matrix_pkg::PLANE_W-1:0] p);
        return {pixel[led_matrix_pkg::BLUE_LSB + p],
                pixel[led_matrix_pkg::GREEN_LSB + 1 + p],
                pixel[led_matrix_pkg::RED_LSB + p]};
    endfunction

    // Plane 0 is shifted before the latch that advances row_addr
    always_comb begin
        fetch_row = row_addr;
        if (plane == '0) begin
            if (row_addr == led_matrix_pkg::ROW_LAST) fetch_row = '0;
            else fetch_row = row_addr + 1'b1;
        end
    end

    assign top_addr   = {1'b0, fetch_row, col_addr}; // Row * 32 + column
    assign rd.rd_en   = load | top_ready;
    assign rd.rd_addr = load ? top_addr : top_addr_q + led_matrix_pkg::BOT_OFFSET;
    assign plane_on   = plane_enable[plane_q];

    always_ff @(posedge clk_in or negedge rst_n) begin
        if (!rst_n) begin
            top_ready <= 1'b0;
            bot_ready <= 1'b0;
            rgb_top   <= '0;
            rgb_bot   <= '0;
        end else begin
            top_ready <= load;
            bot_ready <= top_ready;
            if (bot_ready) begin // Both halves change together
                rgb_top <= top_bits & {3{plane_on}};
                rgb_bot <= plane_bits(rd.rd_data, plane_q) & {3{plane_on}};
            end
        end
    end

    always_ff @(posedge clk_in) begin
        if (load) begin
            top_addr_q <= top_addr;
            plane_q    <= plane;
        end
        if (top_ready) top_bits <= plane_bits(rd.rd_data, plane_q);
    end

endmodule

/* hw/led_matrix_pkg.sv */
package led_matrix_pkg;

    // Panel geometry, scanned as two halves of 8 rows
    localparam int PANEL_WIDTH       = 32;
    localparam int PANEL_HALF_HEIGHT = 8;
    localparam int COL_W             = 5;
    localparam int ROW_W             = 3;
    localparam int PIX_ADDR_W        = 9;  // Row * 32 + column
    localparam int BYTE_ADDR_W       = 10; // Two bytes per pixel
    localparam int FB_WORDS          = 1 << PIX_ADDR_W;

    localparam logic [COL_W-1:0] COL_LAST = COL_W'(PANEL_WIDTH - 1);
    localparam logic [ROW_W-1:0] ROW_LAST = ROW_W'(PANEL_HALF_HEIGHT - 1);
    localparam logic [PIX_ADDR_W-1:0] BOT_OFFSET = PIX_ADDR_W'(PANEL_HALF_HEIGHT * PANEL_WIDTH);

    // Brightness planes, binary weighted
    localparam int NUM_PLANES = 5;
    localparam int PLANE_W    = 3;
    localparam logic [PLANE_W-1:0] PLANE_LAST = PLANE_W'(NUM_PLANES - 1);

    // rgb565 field positions, green uses its upper 5 bits
    localparam int RED_LSB   = 11;
    localparam int GREEN_LSB = 5;
    localparam int BLUE_LSB  = 0;

    // UART bit timing
    localparam int CLKS_PER_BIT = 8;
    localparam int UART_CNT_W   = $clog2(CLKS_PER_BIT);
    localparam logic [UART_CNT_W-1:0] TICK_LAST = UART_CNT_W'(CLKS_PER_BIT - 1);
    localparam logic [UART_CNT_W-1:0] TICK_HALF = UART_CNT_W'(CLKS_PER_BIT / 2 - 1);

    localparam logic [7:0] CMD_FRAME  = 8'h46; // 1024 image bytes follow
    localparam logic [7:0] CMD_BRIGHT = 8'h42; // One plane mask byte follows

    // Display window of plane p is OE_UNIT << p cycles
    localparam int OE_UNIT = 4;
    localparam int SHOW_W  = $clog2(OE_UNIT << NUM_PLANES);
    localparam logic [SHOW_W-1:0] OE_UNIT_LEN = SHOW_W'(OE_UNIT);

endpackage

/* hw/led_matrix_top.sv */
`timescale 1ns/100ps

module led_matrix_top (
    input  logic                             clk_in,
    input  logic                             rst_n,
    input  logic                             uart_rx,
    output logic [2:0]                       rgb1, // Top half
    output logic [2:0]                       rgb2, // Bottom half
    output logic [led_matrix_pkg::ROW_W-1:0] row_addr,
    output logic                             clk_pixel,
    output logic                             row_latch,
    output logic                             oe_n
);

    logic [7:0]                              rx_data;
    logic                                    rx_valid;
    logic                                    wr_en;
    logic [led_matrix_pkg::BYTE_ADDR_W-1:0]  wr_addr;
    logic [7:0]                              wr_data;
    logic [led_matrix_pkg::NUM_PLANES-1:0]   plane_enable;
    logic [led_matrix_pkg::COL_W-1:0]        col_addr;
    logic [led_matrix_pkg::PLANE_W-1:0]      plane;
    logic                                    load;
    logic                                    oe;

    fb_read_if fb_rd ();

    uart_rx uart_rx_i (
        .clk_in   (clk_in),
        .rst_n    (rst_n),
        .rx       (uart_rx),
        .rx_data  (rx_data),
        .rx_valid (rx_valid)
    );

    control_module ctrl_i (
        .clk_in       (clk_in),
        .rst_n        (rst_n),
        .rx_data      (rx_data),
        .rx_valid     (rx_valid),
        .wr_en        (wr_en),
        .wr_addr      (wr_addr),
        .wr_data      (wr_data),
        .plane_enable (plane_enable)
    );

    framebuffer fb_i (
        .clk_in  (clk_in),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .rd      (fb_rd.mem)
    );

    matrix_scan scan_i (
        .clk_in    (clk_in),
        .rst_n     (rst_n),
        .col_addr  (col_addr),
        .row_addr  (row_addr),
        .plane     (plane),
        .load      (load),
        .clk_pixel (clk_pixel),
        .row_latch (row_latch),
        .oe        (oe)
    );

    framebuffer_fetch fetch_i (
        .clk_in       (clk_in),
        .rst_n        (rst_n),
        .col_addr     (col_addr),
        .row_addr     (row_addr),
        .plane        (plane),
        .load         (load),
        .plane_enable (plane_enable),
        .rd           (fb_rd.fetch),
        .rgb_top      (rgb1),
        .rgb_bot      (rgb2)
    );

    assign oe_n = ~oe; // Panel OE is active low

endmodule

/* hw/matrix_scan.sv */
`timescale 1ns/100ps

module matrix_scan (
    input  logic                               clk_in,
    input  logic                               rst_n,
    output logic [led_matrix_pkg::COL_W-1:0]   col_addr,
    output logic [led_matrix_pkg::ROW_W-1:0]   row_addr,
    output logic [led_matrix_pkg::PLANE_W-1:0] plane,
    output logic                               load,
    output logic                               clk_pixel,
    output logic                               row_latch,
    output logic                               oe
);

    typedef enum logic [1:0] {
        SCAN_SHIFT, // 4 cycles per column
        SCAN_BLANK,
        SCAN_LATCH,
        SCAN_SHOW
    } scan_state_t;

    scan_state_t                       state;
    logic [1:0]                        phase;
    logic [led_matrix_pkg::SHOW_W-1:0] show_cnt;
    logic [led_matrix_pkg::SHOW_W-1:0] show_len;

    assign show_len = led_matrix_pkg::OE_UNIT_LEN << plane; // Binary weighted

    // row_addr holds the row on display; plane 0 shifts the row after it
    always_ff @(posedge clk_in or negedge rst_n) begin
        if (!rst_n) begin
            state    <= SCAN_SHIFT;
            phase    <= '0;
            col_addr <= '0;
            plane    <= '0;
            row_addr <= led_matrix_pkg::ROW_LAST; // First latch lands on row 0
            show_cnt <= '0;
        end else begin
            case (state)
                SCAN_SHIFT: begin
                    phase <= phase + 1'b1;
                    if (phase == 2'd3) begin
                        col_addr <= col_addr + 1'b1; // Wraps to 0 after the last column
                        if (col_addr == led_matrix_pkg::COL_LAST) state <= SCAN_BLANK;
                    end
                end
                SCAN_BLANK: begin
                    if (plane == '0) begin
                        if (row_addr == led_matrix_pkg::ROW_LAST) row_addr <= '0;
                        else row_addr <= row_addr + 1'b1;
                    end
                    state <= SCAN_LATCH;
                end
                SCAN_LATCH: begin
                    show_cnt <= '0;
                    state    <= SCAN_SHOW;
                end
                SCAN_SHOW: begin
                    show_cnt <= show_cnt + 1'b1;
                    if (show_cnt == show_len - 1'b1) begin
                        if (plane == led_matrix_pkg::PLANE_LAST) plane <= '0;
                        else plane <= plane + 1'b1;
                        state <= SCAN_SHIFT;
                    end
                end
                default: state <= SCAN_SHIFT;
            endcase
        end
    end

    // Panel strobes decoded from the scan state
    assign load      = (state == SCAN_SHIFT) && (phase == 2'd0);
    assign clk_pixel = (state == SCAN_SHIFT) && (phase == 2'd3); // Data stable by then
    assign row_latch = (state == SCAN_LATCH);
    assign oe        = (state == SCAN_SHOW);

endmodule

/* hw/uart_rx.sv */
`timescale 1ns/100ps

module uart_rx (
    input  logic       clk_in,
    input  logic       rst_n,
    input  logic       rx,
    output logic [7:0] rx_data,
    output logic       rx_valid
);

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } rx_state_t;

    rx_state_t                               state;
    logic                                    rx_meta;
    logic                                    rx_sync;
    logic [led_matrix_pkg::UART_CNT_W-1:0]   tick;
    logic [2:0]                              bit_idx;

    // Line idles high
    always_ff @(posedge clk_in or negedge rst_n) begin
        if (!rst_n) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
        end else begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
        end
    end

    always_ff @(posedge clk_in or negedge rst_n) begin
        if (!rst_n) begin
            state    <= RX_IDLE;
            tick     <= '0;
            bit_idx  <= '0;
            rx_valid <= 1'b0;
        end else begin
            rx_valid <= 1'b0;
            tick     <= tick + 1'b1;
            case (state)
                RX_IDLE: begin
                    tick    <= '0;
                    bit_idx <= '0;
                    if (!rx_sync) state <= RX_START;
                end
                RX_START: if (tick == led_matrix_pkg::TICK_HALF) begin
                    tick  <= '0;
                    state <= rx_sync ? RX_IDLE : RX_DATA; // Glitch, not a start bit
                end
                RX_DATA: if (tick == led_matrix_pkg::TICK_LAST) begin
                    bit_idx <= bit_idx + 1'b1;
                    if (bit_idx == 3'd7) state <= RX_STOP;
                end
                RX_STOP: if (tick == led_matrix_pkg::TICK_LAST) begin
                    rx_valid <= rx_sync; // Framing error drops the byte
                    state    <= RX_IDLE;
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

    // LSB first, sampled mid bit
    always_ff @(posedge clk_in) begin
        if (state == RX_DATA && tick == led_matrix_pkg::TICK_LAST) rx_data <= {rx_sync, rx_data[7:1]};
    end

endmodule

/* led_matrix.f */
hw/led_matrix_pkg.sv
hw/fb_read_if.sv
hw/uart_rx.sv
hw/control_module.sv
hw/framebuffer.sv
hw/matrix_scan.sv
hw/framebuffer_fetch.sv
hw/led_matrix_top.sv
tests/led_matrix_assertions.sv
tests/led_matrix_tb.sv

/* tests/led_matrix_assertions.sv */
`timescale 1ns/100ps

module led_matrix_assertions (
    input logic                             clk_in,
    input logic                             rst_n,
    input logic [led_matrix_pkg::ROW_W-1:0] row_addr,
    input logic                             row_latch,
    input logic                             oe
);

    localparam int SHIFT_CYCLES = led_matrix_pkg::PANEL_WIDTH * 4; // First shift pass

    int unsigned error_count = 0; // Failed assertions so far
    logic [7:0]  cycles_since_reset;

    always_ff @(posedge clk_in or negedge rst_n) begin
        if (!rst_n) begin
            cycles_since_reset <= '0;
        end else if (cycles_since_reset != '1) begin
            cycles_since_reset <= cycles_since_reset + 1'b1;
        end
    end

    // Panel stays dark while the first row shifts in
    a_dark_after_reset: assert property (@(posedge clk_in) disable iff (!rst_n)
        (cycles_since_reset < SHIFT_CYCLES) |-> (!oe && !row_latch))
        else begin
            $error("Panel lit or latched during the first shift pass");
            error_count++;
        end

    a_latch_while_dark: assert property (@(posedge clk_in) disable iff (!rst_n)
        row_latch |-> !oe)
        else begin
            $error("Row latch pulsed while output enable was on");
            error_count++;
        end

    a_latch_single: assert property (@(posedge clk_in) disable iff (!rst_n)
        row_latch |=> !row_latch)
        else begin
            $error("Row latch held for more than one cycle");
            error_count++;
        end

    // Row address only moves together with the latch
    a_row_on_latch: assert property (@(posedge clk_in) disable iff (!rst_n)
        !$stable(row_addr) |-> row_latch)
        else begin
            $error("Row address changed outside a latch cycle");
            error_count++;
        end

    a_show_after_latch: assert property (@(posedge clk_in) disable iff (!rst_n)
        $rose(oe) |-> $past(row_latch))
        else begin
            $error("Display window opened without a row latch");
            error_count++;
        end

endmodule

bind matrix_scan led_matrix_assertions scan_checks_i (
    .clk_in    (clk_in),
    .rst_n     (rst_n),
    .row_addr  (row_addr),
    .row_latch (row_latch),
    .oe        (oe)
);

/* tests/led_matrix_tb.sv */
`timescale 1ns/100ps

module led_matrix_tb;

    localparam int RESET_CYCLES = 16;
    localparam int WIDTH        = led_matrix_pkg::PANEL_WIDTH;
    localparam int HALF         = led_matrix_pkg::PANEL_HALF_HEIGHT;
    localparam int PLANES       = led_matrix_pkg::NUM_PLANES;
    localparam int BYTE_CYCLES  = 10 * led_matrix_pkg::CLKS_PER_BIT; // 8N1 frame
    localparam int ROW_CYCLES   = PLANES * (WIDTH * 4 + 2)
                                + led_matrix_pkg::OE_UNIT * ((1 << PLANES) - 1);
    localparam int SCAN_CYCLES  = ROW_CYCLES * HALF;
    // Upload plus command bytes, then a sync and a checked scan per pass, with margin
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + 1030 * BYTE_CYCLES + 6 * SCAN_CYCLES;

    logic       clk_in;
    logic       rst_n;
    logic       uart_rx;
    logic [2:0] rgb1;
    logic [2:0] rgb2;
    logic [2:0] row_addr;
    logic       clk_pixel;
    logic       row_latch;
    logic       oe_n;

    logic [15:0] model_fb [0:led_matrix_pkg::FB_WORDS-1]; // Reference image
    logic [31:0] lcg_state = 32'hab1b_86fb;
    int          cycle_count = 0;

    led_matrix_top dut_i (
        .clk_in    (clk_in),
        .rst_n     (rst_n),
        .uart_rx   (uart_rx),
        .rgb1      (rgb1),
        .rgb2      (rgb2),
        .row_addr  (row_addr),
        .clk_pixel (clk_pixel),
        .row_latch (row_latch),
        .oe_n      (oe_n)
    );

    initial begin
        clk_in = 1'b0;
        forever #4 clk_in = ~clk_in;
    end

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("ERRORS FOUND");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string name, input int expected, input int actual);
        $display("CHECK FAILED %s expected %0d actual %0d", name, expected, actual);
        $display("ERRORS FOUND");
        $fatal(1);
    endtask

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // rgb565 plane bits as {blue, green, red}, green skips its lowest bit
    function automatic logic [2:0] expected_bits(input logic [15:0] pixel, input int p,
                                                 input logic [4:0] mask);
        if (!mask[p]) return 3'b000;
        return {pixel[p], pixel[6 + p], pixel[11 + p]};
    endfunction

    task automatic send_byte(input logic [7:0] data);
        logic [9:0] frame;
        frame = {1'b1, data, 1'b0}; // Stop, data LSB first, start
        for (int i = 0; i < 10; i++) begin
            @(posedge clk_in);
            #1;
            uart_rx = frame[i];
            repeat (led_matrix_pkg::CLKS_PER_BIT - 1) @(posedge clk_in);
        end
    endtask

    task automatic upload_frame();
        logic [7:0] data;
        send_byte(led_matrix_pkg::CMD_FRAME);
        for (int n = 0; n < 2 * led_matrix_pkg::FB_WORDS; n++) begin
            lcg_state = lcg_step(lcg_state);
            data = lcg_state[31:24];
            if (n % 2) model_fb[n / 2][15:8] = data;
            else model_fb[n / 2][7:0] = data;
            send_byte(data);
        end
    endtask

    // Returns at the latch that moves row_addr onto row 0
    task automatic wait_row_start();
        logic [2:0] last_row;
        last_row = row_addr;
        @(negedge clk_in);
        while (!(row_latch && row_addr == 3'd0 && last_row != 3'd0)) begin
            last_row = row_addr;
            @(negedge clk_in);
        end
    endtask

    task automatic measure_window(input string name, input int p);
        int run;
        run = 0;
        @(negedge clk_in);
        while (oe_n == 1'b0) begin
            run++;
            @(negedge clk_in);
        end
        assert (run == (led_matrix_pkg::OE_UNIT << p))
            else report_mismatch($sformatf("%s oe_n low run plane %0d", name, p),
                                 led_matrix_pkg::OE_UNIT << p, run);
    endtask

    task automatic check_shift(input string name, input int row, input int p,
                               input logic [4:0] mask);
        logic [2:0] exp_top;
        logic [2:0] exp_bot;
        for (int col = 0; col < WIDTH; col++) begin
            @(negedge clk_in);
            while (!clk_pixel) @(negedge clk_in);
            exp_top = expected_bits(model_fb[row * WIDTH + col], p, mask);
            exp_bot = expected_bits(model_fb[(row + HALF) * WIDTH + col], p, mask);
            assert (rgb1 == exp_top)
                else report_mismatch($sformatf("%s rgb1 row %0d col %0d plane %0d",
                                               name, row, col, p), exp_top, rgb1);
            assert (rgb2 == exp_bot)
                else report_mismatch($sformatf("%s rgb2 row %0d col %0d plane %0d",
                                               name, row + HALF, col, p), exp_bot, rgb2);
        end
    endtask

    // One full scan, starting with the plane 0 window of row 0
    task automatic check_scan(input string name, input logic [4:0] mask);
        int row;
        int p;
        int show_plane;
        wait_row_start();
        row = 0;
        p = 1;
        show_plane = 0;
        repeat (PLANES * HALF) begin
            measure_window(name, show_plane);
            check_shift(name, row, p, mask);
            @(negedge clk_in);
            while (!row_latch) @(negedge clk_in);
            assert (row_addr == row)
                else report_mismatch($sformatf("%s row_addr at latch", name), row, row_addr);
            show_plane = p;
            if (p == PLANES - 1) begin
                p = 0;
                row = (row + 1) % HALF;
            end else begin
                p++;
            end
        end
    endtask

    always @(posedge clk_in) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            report_failure($sformatf("Timeout after %0d cycles, checks did not finish",
                                     cycle_count));
        end
    end

    always @(negedge clk_in) begin
        if (dut_i.scan_i.scan_checks_i.error_count != 0) begin
            report_failure("A scan protocol assertion in matrix_scan failed");
        end
    end

    initial begin
        rst_n   = 1'b0;
        uart_rx = 1'b1; // Line idles high
        repeat (RESET_CYCLES) @(posedge clk_in);
        #1;
        rst_n = 1'b1;

        upload_frame();
        repeat (led_matrix_pkg::CLKS_PER_BIT) @(posedge clk_in);
        check_scan("frame_upload", 5'h1f);

        send_byte(led_matrix_pkg::CMD_BRIGHT);
        send_byte(8'h05); // Planes 0 and 2 only
        repeat (led_matrix_pkg::CLKS_PER_BIT) @(posedge clk_in);
        check_scan("plane_mask", 5'h05);

        if (dut_i.scan_i.scan_checks_i.error_count != 0) begin
            report_failure("A scan protocol assertion in matrix_scan failed");
        end else begin
            $display("NO ERRORS");
            $finish;
        end
    end

endmodule
